// File: hdl/jtsd_sdram_pkg.sv
// SDRAM geometry and command set
package jtsd_sdram_pkg;

    // 16-bit device, 4 banks of 8192 rows by 512 columns
    localparam int ROW_W  = 13;
    localparam int COL_W  = 9;
    localparam int BANK_W = 2;
    localparam int DQ_W   = 16;

    // Timing in clk_rom cycles
    localparam int T_RCD   = 2;
    localparam int CAS_LAT = 2;
    localparam int T_RP    = 2;
    localparam int T_RFC   = 7;

    // Encoded as {nRAS, nCAS, nWE} with nCS low
    typedef enum logic [2:0] {
        NOP       = 3'b111,
        ACTIVE    = 3'b011,
        READ      = 3'b101,
        WRITE     = 3'b100,
        PRECHARGE = 3'b010,
        REFRESH   = 3'b001,
        LOAD_MODE = 3'b000
    } sdram_cmd_e;

    // Sequencer states, RFSH_WAIT covers the auto-refresh time
    typedef enum logic [3:0] {
        INIT_WAIT,
        INIT_PRECH,
        INIT_RFSH,
        INIT_MODE,
        IDLE,
        ACTIVATE,
        ACCESS,
        RECOVER,
        RFSH_WAIT
    } ctrl_state_e;

endpackage

// File: hdl/jtsd_board_pkg.sv
// Bank port sharing definitions
package jtsd_board_pkg;

    // One requester per SDRAM bank
    localparam int NPORTS = 4;

    typedef logic [$clog2(NPORTS)-1:0] port_idx_t;

endpackage

// File: hdl/jtsd_reset.sv
// Board reset generation
`timescale 1ns/1ps

module jtsd_reset #(
    parameter int RST_CYCLES = 16
)(
    input  logic clk_rom,
    input  logic arst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic sdram_init,
    output logic rst,
    output logic game_rst
);

    localparam int CW = $clog2(RST_CYCLES);

    logic [1:0]    pll_s;
    logic [1:0]    req_s;
    logic [CW-1:0] cnt;
    logic          hold;

    // Either source restarts the stretch
    assign hold = !pll_s[1] || req_s[1];

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            pll_s    <= '0;
            req_s    <= '0;
            cnt      <= '0;
            rst      <= 1'b1;
            game_rst <= 1'b1;
        end else begin
            pll_s    <= {pll_s[0], pll_locked};
            req_s    <= {req_s[0], rst_req};
            // Game logic waits for the SDRAM to be usable
            game_rst <= rst | sdram_init;
            if (hold) begin
                cnt <= '0;
                rst <= 1'b1;
            end else if (cnt == CW'(RST_CYCLES - 1)) begin
                rst <= 1'b0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/jtsd_bank_port.sv
// Bank requester front end
`timescale 1ns/1ps

module jtsd_bank_port #(
    parameter bit HAS_WR = 1'b0
)(
    input  logic clk_rom,
    input  logic arst_n,
    input  logic rd,
    input  logic wr,
    output logic req,
    input  logic gnt_ack,
    input  logic gnt_dok,
    input  logic gnt_rdy,
    output logic ack,
    output logic dok,
    output logic rdy
);

    logic busy;

    // A held rd after ack must not start a second access
    assign req = (rd | (HAS_WR & wr)) & ~busy;

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            ack  <= 1'b0;
            dok  <= 1'b0;
            rdy  <= 1'b0;
            busy <= 1'b0;
        end else begin
            ack <= gnt_ack;
            dok <= gnt_dok;
            rdy <= gnt_rdy;
            if (ack) begin
                busy <= 1'b1;
            end else if (rdy) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/jtsd_arbiter.sv
// Round-robin arbiter for the bank ports
`timescale 1ns/1ps

module jtsd_arbiter #(
    parameter int AW = 22
)(
    input  logic                              clk_rom,
    input  logic                              arst_n,
    input  logic [jtsd_board_pkg::NPORTS-1:0] req,
    input  logic [AW-1:0]                     ba0_addr,
    input  logic [AW-1:0]                     ba1_addr,
    input  logic [AW-1:0]                     ba2_addr,
    input  logic [AW-1:0]                     ba3_addr,
    input  logic                              wr0,
    input  logic [jtsd_sdram_pkg::DQ_W-1:0]   din,
    input  logic [jtsd_sdram_pkg::DQ_W/8-1:0] din_m,
    input  logic                              idle,
    input  logic                              ctrl_ack,
    input  logic                              ctrl_dok,
    input  logic                              ctrl_rdy,
    output logic                              start,
    output logic [AW-1:0]                     addr,
    output jtsd_board_pkg::port_idx_t         bank,
    output logic                              we,
    output logic [jtsd_sdram_pkg::DQ_W-1:0]   wdata,
    output logic [jtsd_sdram_pkg::DQ_W/8-1:0] wmask,
    output logic [jtsd_board_pkg::NPORTS-1:0] gnt_ack,
    output logic [jtsd_board_pkg::NPORTS-1:0] gnt_dok,
    output logic [jtsd_board_pkg::NPORTS-1:0] gnt_rdy
);
    import jtsd_board_pkg::*;

    logic [AW-1:0]     port_addr [NPORTS];
    port_idx_t         owner;
    port_idx_t         winner;
    logic              found;
    logic              active;
    logic              grant;
    logic [NPORTS-1:0] owner_oh;

    assign port_addr[0] = ba0_addr;
    assign port_addr[1] = ba1_addr;
    assign port_addr[2] = ba2_addr;
    assign port_addr[3] = ba3_addr;

    // One access in flight, so the controller must also be free
    assign grant = idle && !active && found;

    // The bank number is the port number
    assign bank     = owner;
    assign owner_oh = NPORTS'(1) << owner;
    assign gnt_ack  = owner_oh & {NPORTS{ctrl_ack}};
    assign gnt_dok  = owner_oh & {NPORTS{ctrl_dok}};
    assign gnt_rdy  = owner_oh & {NPORTS{ctrl_rdy}};

    // Search starts after the last winner
    always_comb begin
        port_idx_t cand;
        found  = 1'b0;
        winner = owner;
        for (int k = 1; k <= NPORTS; k++) begin
            cand = port_idx_t'(owner + k);
            if (!found && req[cand]) begin
                found  = 1'b1;
                winner = cand;
            end
        end
    end

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            start  <= 1'b0;
            active <= 1'b0;
            owner  <= port_idx_t'(NPORTS - 1);
        end else begin
            start <= grant;
            if (grant) begin
                active <= 1'b1;
                owner  <= winner;
            end else if (ctrl_rdy) begin
                active <= 1'b0;
            end
        end
    end

    // Held stable for the controller until the next grant
    always_ff @(posedge clk_rom) begin
        if (grant) begin
            addr  <= port_addr[winner];
            we    <= wr0 && (winner == '0);
            wdata <= din;
            wmask <= din_m;
        end
    end

endmodule

// File: hdl/jtsd_sdram_ctrl.sv
// SDRAM command sequencer
`timescale 1ns/1ps

module jtsd_sdram_ctrl #(
    parameter int AW          = 22,
    parameter int INIT_CYCLES = 9600
)(
    input  logic                              clk_rom,
    input  logic                              arst_n,
    input  logic                              rst,
    input  logic                              start,
    input  logic [AW-1:0]                     addr,
    input  logic [jtsd_sdram_pkg::BANK_W-1:0] bank,
    input  logic                              we,
    input  logic [jtsd_sdram_pkg::DQ_W-1:0]   wdata,
    input  logic [jtsd_sdram_pkg::DQ_W/8-1:0] wmask,
    input  logic                              rfsh,
    output logic                              idle,
    output logic                              ack,
    output logic                              dok,
    output logic                              rdy,
    output logic [jtsd_sdram_pkg::DQ_W-1:0]   dout,
    output logic                              sdram_init,
    inout  wire  [jtsd_sdram_pkg::DQ_W-1:0]   sdram_dq,
    output logic [jtsd_sdram_pkg::ROW_W-1:0]  sdram_a,
    output logic [jtsd_sdram_pkg::BANK_W-1:0] sdram_ba,
    output logic                              sdram_dqml,
    output logic                              sdram_dqmh,
    output logic                              sdram_nwe,
    output logic                              sdram_ncas,
    output logic                              sdram_nras,
    output logic                              sdram_ncs,
    output logic                              sdram_cke
);
    import jtsd_sdram_pkg::*;

    localparam int CNT_W = $clog2(INIT_CYCLES + T_RFC);

    // A10 selects all banks on PRECHARGE and auto-precharge on READ/WRITE
    localparam logic [ROW_W-1:0] AUTO_PRECH = ROW_W'(1) << 10;
    // CL 2, sequential, burst length 1
    localparam logic [ROW_W-1:0] MODE_WORD  = ROW_W'(13'h020);

    ctrl_state_e        st;
    sdram_cmd_e         cmd;
    logic [CNT_W-1:0]   cnt;
    logic               rfsh_l;
    logic               rfsh_pend;
    logic               rfsh_2nd;
    logic               dq_oe;
    logic [DQ_W/8-1:0]  dqm;

    // Pending refresh keeps the arbiter away
    assign idle = (st == IDLE) && !rfsh_pend;
    // Strobes lead the bank port register by one cycle
    assign ack  = (st == ACTIVATE) && (cnt == CNT_W'(T_RCD - 1));
    assign dok  = (st == ACCESS) && !we && (cnt == CNT_W'(CAS_LAT));
    assign rdy  = (st == RECOVER) && (cnt == '0);

    assign {sdram_nras, sdram_ncas, sdram_nwe} = cmd;
    assign {sdram_dqmh, sdram_dqml} = dqm;
    assign sdram_ncs = 1'b0;
    assign sdram_cke = 1'b1;
    assign sdram_dq  = dq_oe ? wdata : 'z;

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            st         <= INIT_WAIT;
            cmd        <= NOP;
            cnt        <= '0;
            sdram_init <= 1'b1;
            sdram_a    <= '0;
            sdram_ba   <= '0;
            dqm        <= '0;
            dq_oe      <= 1'b0;
            rfsh_l     <= 1'b0;
            rfsh_pend  <= 1'b0;
            rfsh_2nd   <= 1'b0;
        end else begin
            cmd    <= NOP;
            dqm    <= '0;
            dq_oe  <= 1'b0;
            cnt    <= cnt + 1'b1;
            rfsh_l <= rfsh;
            if (rst) begin
                st         <= INIT_WAIT;
                cnt        <= '0;
                sdram_init <= 1'b1;
            end else begin
                case (st)
                    INIT_WAIT: if (cnt == CNT_W'(INIT_CYCLES - 1)) begin
                        cmd     <= PRECHARGE;
                        sdram_a <= AUTO_PRECH;
                        st      <= INIT_PRECH;
                        cnt     <= '0;
                    end
                    INIT_PRECH: if (cnt == CNT_W'(T_RP - 1)) begin
                        cmd      <= REFRESH;
                        rfsh_2nd <= 1'b0;
                        st       <= INIT_RFSH;
                        cnt      <= '0;
                    end
                    // Two refresh cycles before the mode register
                    INIT_RFSH: if (cnt == CNT_W'(T_RFC - 1)) begin
                        cnt <= '0;
                        if (rfsh_2nd) begin
                            cmd      <= LOAD_MODE;
                            sdram_a  <= MODE_WORD;
                            sdram_ba <= '0;
                            st       <= INIT_MODE;
                        end else begin
                            cmd      <= REFRESH;
                            rfsh_2nd <= 1'b1;
                        end
                    end
                    // tMRD of two cycles
                    INIT_MODE: if (cnt == CNT_W'(1)) begin
                        st         <= IDLE;
                        sdram_init <= 1'b0;
                    end
                    IDLE: begin
                        if (start) begin
                            cmd      <= ACTIVE;
                            sdram_ba <= bank;
                            sdram_a  <= addr[AW-1 -: ROW_W];
                            st       <= ACTIVATE;
                            cnt      <= '0;
                        end else if (rfsh_pend) begin
                            cmd       <= REFRESH;
                            rfsh_pend <= 1'b0;
                            st        <= RFSH_WAIT;
                            cnt       <= '0;
                        end
                    end
                    ACTIVATE: if (ack) begin
                        cmd     <= we ? WRITE : READ;
                        sdram_a <= AUTO_PRECH | ROW_W'(addr[COL_W-1:0]);
                        dq_oe   <= we;
                        dqm     <= we ? wmask : '0;
                        st      <= ACCESS;
                        cnt     <= '0;
                    end
                    // Reads wait for the CAS latency, writes for precharge
                    ACCESS: if (cnt == CNT_W'(we ? T_RP - 1 : CAS_LAT)) begin
                        st  <= RECOVER;
                        cnt <= '0;
                    end
                    RECOVER: if (cnt == CNT_W'(T_RP - 1)) begin
                        st <= IDLE;
                    end
                    RFSH_WAIT: if (cnt == CNT_W'(T_RFC - 1)) begin
                        st <= IDLE;
                    end
                    default: st <= INIT_WAIT;
                endcase
            end
            // A new blanking edge wins over the clear
            if (rfsh && !rfsh_l) begin
                rfsh_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_rom) begin
        if (dok) begin
            dout <= sdram_dq;
        end
    end

endmodule

// File: hdl/jtsd_board.sv
// Four-bank SDRAM board top
`timescale 1ns/1ps

module jtsd_board #(
    parameter int AW          = 22,
    parameter int INIT_CYCLES = 9600,
    parameter int RST_CYCLES  = 16
)(
    input  logic                              clk_rom,
    input  logic                              arst_n,
    input  logic                              pll_locked,
    input  logic                              rst_req,
    input  logic                              lhbl,
    input  logic [AW-1:0]                     ba0_addr,
    input  logic [AW-1:0]                     ba1_addr,
    input  logic [AW-1:0]                     ba2_addr,
    input  logic [AW-1:0]                     ba3_addr,
    input  logic [jtsd_board_pkg::NPORTS-1:0] rd,
    input  logic                              wr0,
    input  logic [jtsd_sdram_pkg::DQ_W-1:0]   ba0_din,
    input  logic [jtsd_sdram_pkg::DQ_W/8-1:0] ba0_din_m,
    output logic [jtsd_board_pkg::NPORTS-1:0] ack,
    output logic [jtsd_board_pkg::NPORTS-1:0] dok,
    output logic [jtsd_board_pkg::NPORTS-1:0] rdy,
    output logic [jtsd_sdram_pkg::DQ_W-1:0]   sdram_dout,
    output logic                              rst,
    output logic                              game_rst,
    output logic                              sdram_init,
    inout  wire  [jtsd_sdram_pkg::DQ_W-1:0]   sdram_dq,
    output logic [jtsd_sdram_pkg::ROW_W-1:0]  sdram_a,
    output logic [jtsd_sdram_pkg::BANK_W-1:0] sdram_ba,
    output logic                              sdram_dqml,
    output logic                              sdram_dqmh,
    output logic                              sdram_nwe,
    output logic                              sdram_ncas,
    output logic                              sdram_nras,
    output logic                              sdram_ncs,
    output logic                              sdram_cke
);
    import jtsd_sdram_pkg::*;
    import jtsd_board_pkg::*;

    logic [NPORTS-1:0] req;
    logic [NPORTS-1:0] gnt_ack;
    logic [NPORTS-1:0] gnt_dok;
    logic [NPORTS-1:0] gnt_rdy;
    logic              start;
    logic              idle;
    logic              we;
    logic              ctrl_ack;
    logic              ctrl_dok;
    logic              ctrl_rdy;
    logic [AW-1:0]     addr;
    port_idx_t         bank;
    logic [DQ_W-1:0]   wdata;
    logic [DQ_W/8-1:0] wmask;

    jtsd_reset #(
        .RST_CYCLES ( RST_CYCLES    )
    ) u_reset(
        .clk_rom    ( clk_rom       ),
        .arst_n     ( arst_n        ),
        .pll_locked ( pll_locked    ),
        .rst_req    ( rst_req       ),
        .sdram_init ( sdram_init    ),
        .rst        ( rst           ),
        .game_rst   ( game_rst      )
    );

    // Only bank 0 can write
    for (genvar i = 0; i < NPORTS; i++) begin : g_port
        jtsd_bank_port #(
            .HAS_WR     ( i == 0        )
        ) u_port(
            .clk_rom    ( clk_rom       ),
            .arst_n     ( arst_n        ),
            .rd         ( rd[i]         ),
            .wr         ( i == 0 ? wr0 : 1'b0 ),
            .req        ( req[i]        ),
            .gnt_ack    ( gnt_ack[i]    ),
            .gnt_dok    ( gnt_dok[i]    ),
            .gnt_rdy    ( gnt_rdy[i]    ),
            .ack        ( ack[i]        ),
            .dok        ( dok[i]        ),
            .rdy        ( rdy[i]        )
        );
    end

    jtsd_arbiter #(
        .AW         ( AW            )
    ) u_arbiter(
        .clk_rom    ( clk_rom       ),
        .arst_n     ( arst_n        ),
        .req        ( req           ),
        .ba0_addr   ( ba0_addr      ),
        .ba1_addr   ( ba1_addr      ),
        .ba2_addr   ( ba2_addr      ),
        .ba3_addr   ( ba3_addr      ),
        .wr0        ( wr0           ),
        .din        ( ba0_din       ),
        .din_m      ( ba0_din_m     ),
        .idle       ( idle          ),
        .ctrl_ack   ( ctrl_ack      ),
        .ctrl_dok   ( ctrl_dok      ),
        .ctrl_rdy   ( ctrl_rdy      ),
        .start      ( start         ),
        .addr       ( addr          ),
        .bank       ( bank          ),
        .we         ( we            ),
        .wdata      ( wdata         ),
        .wmask      ( wmask         ),
        .gnt_ack    ( gnt_ack       ),
        .gnt_dok    ( gnt_dok       ),
        .gnt_rdy    ( gnt_rdy       )
    );

    jtsd_sdram_ctrl #(
        .AW          ( AW           ),
        .INIT_CYCLES ( INIT_CYCLES  )
    ) u_sdram(
        .clk_rom    ( clk_rom       ),
        .arst_n     ( arst_n        ),
        .rst        ( rst           ),
        .start      ( start         ),
        .addr       ( addr          ),
        .bank       ( bank          ),
        .we         ( we            ),
        .wdata      ( wdata         ),
        .wmask      ( wmask         ),
        // One refresh per line, on the start of horizontal blank
        .rfsh       ( ~lhbl         ),
        .idle       ( idle          ),
        .ack        ( ctrl_ack      ),
        .dok        ( ctrl_dok      ),
        .rdy        ( ctrl_rdy      ),
        .dout       ( sdram_dout    ),
        .sdram_init ( sdram_init    ),
        .sdram_dq   ( sdram_dq      ),
        .sdram_a    ( sdram_a       ),
        .sdram_ba   ( sdram_ba      ),
        .sdram_dqml ( sdram_dqml    ),
        .sdram_dqmh ( sdram_dqmh    ),
        .sdram_nwe  ( sdram_nwe     ),
        .sdram_ncas ( sdram_ncas    ),
        .sdram_nras ( sdram_nras    ),
        .sdram_ncs  ( sdram_ncs     ),
        .sdram_cke  ( sdram_cke     )
    );

endmodule

// File: verif/jtsd_sdram_model.sv
// Behavioural SDRAM device
`timescale 1ns/1ps

module jtsd_sdram_model(
    input  logic                              clk,
    inout  wire  [jtsd_sdram_pkg::DQ_W-1:0]   sdram_dq,
    input  logic [jtsd_sdram_pkg::ROW_W-1:0]  sdram_a,
    input  logic [jtsd_sdram_pkg::BANK_W-1:0] sdram_ba,
    input  logic                              sdram_dqml,
    input  logic                              sdram_dqmh,
    input  logic                              sdram_nwe,
    input  logic                              sdram_ncas,
    input  logic                              sdram_nras,
    input  logic                              sdram_ncs,
    input  logic                              sdram_cke,
    output int                                rfsh_cnt
);
    import jtsd_sdram_pkg::*;

    // Sparse storage, untouched words follow the preload rule
    logic [DQ_W-1:0]  mem [int];
    logic [ROW_W-1:0] open_row [4];
    logic             rd_v;
    logic [DQ_W-1:0]  rd_data;
    logic             dq_en;
    logic [DQ_W-1:0]  dq_out;
    logic [DQ_W-1:0]  word;
    int               key;
    sdram_cmd_e       cmd;

    assign cmd      = sdram_cmd_e'({sdram_nras, sdram_ncas, sdram_nwe});
    assign sdram_dq = dq_en ? dq_out : 'z;

    function automatic logic [DQ_W-1:0] read_word(input int k);
        if (mem.exists(k)) begin
            return mem[k];
        end
        return k[15:0] ^ 16'h5a5a;
    endfunction

    initial begin
        rfsh_cnt = 0;
        rd_v     = 1'b0;
        dq_en    = 1'b0;
    end

    // Read data goes out CAS_LAT cycles after the READ command
    always @(posedge clk) begin
        dq_en  <= #1 rd_v;
        dq_out <= #1 rd_data;
        rd_v   <= 1'b0;
        if (!sdram_ncs && sdram_cke) begin
            case (cmd)
                ACTIVE: open_row[sdram_ba] <= sdram_a;
                READ: begin
                    key     = {sdram_ba, open_row[sdram_ba], sdram_a[COL_W-1:0]};
                    rd_v    <= 1'b1;
                    rd_data <= read_word(key);
                end
                WRITE: begin
                    key  = {sdram_ba, open_row[sdram_ba], sdram_a[COL_W-1:0]};
                    word = read_word(key);
                    if (!sdram_dqml) word[7:0] = sdram_dq[7:0];
                    if (!sdram_dqmh) word[15:8] = sdram_dq[15:8];
                    mem[key] = word;
                end
                REFRESH: rfsh_cnt++;
                default: ;
            endcase
        end
    end

endmodule

// File: verif/jtsd_board_tb.sv
// Board testbench
`timescale 1ns/1ps

module jtsd_board_tb;
    import jtsd_sdram_pkg::*;

    localparam int AW          = 22;
    localparam int INIT_CYCLES = 50;

    logic             clk_rom;
    logic             arst_n;
    logic             pll_locked;
    logic             rst_req;
    logic             lhbl;
    logic [AW-1:0]    ba0_addr;
    logic [AW-1:0]    ba1_addr;
    logic [AW-1:0]    ba2_addr;
    logic [AW-1:0]    ba3_addr;
    logic [3:0]       rd;
    logic             wr0;
    logic [15:0]      ba0_din;
    logic [1:0]       ba0_din_m;
    logic [3:0]       ack;
    logic [3:0]       dok;
    logic [3:0]       rdy;
    logic [15:0]      sdram_dout;
    logic             rst;
    logic             game_rst;
    logic             sdram_init;
    wire  [15:0]      sdram_dq;
    logic [12:0]      sdram_a;
    logic [1:0]       sdram_ba;
    logic             sdram_dqml;
    logic             sdram_dqmh;
    logic             sdram_nwe;
    logic             sdram_ncas;
    logic             sdram_nras;
    logic             sdram_ncs;
    logic             sdram_cke;
    int               rfsh_cnt;

    int               errors;
    int               checks;
    int               cycle;
    int               limit;
    int               seed;
    int               pulses;
    logic             gen_stop;
    logic             gen_done;
    int               last_winner;
    logic [15:0]      sb [int];
    byte              op_q [$];
    int               port_q [$];
    logic [31:0]      addr_q [$];
    logic [31:0]      data_q [$];
    logic [31:0]      mask_q [$];
    logic [31:0]      exp_q [$];

    jtsd_board #(
        .AW          ( AW          ),
        .INIT_CYCLES ( INIT_CYCLES )
    ) u_dut(
        .clk_rom    ( clk_rom    ),
        .arst_n     ( arst_n     ),
        .pll_locked ( pll_locked ),
        .rst_req    ( rst_req    ),
        .lhbl       ( lhbl       ),
        .ba0_addr   ( ba0_addr   ),
        .ba1_addr   ( ba1_addr   ),
        .ba2_addr   ( ba2_addr   ),
        .ba3_addr   ( ba3_addr   ),
        .rd         ( rd         ),
        .wr0        ( wr0        ),
        .ba0_din    ( ba0_din    ),
        .ba0_din_m  ( ba0_din_m  ),
        .ack        ( ack        ),
        .dok        ( dok        ),
        .rdy        ( rdy        ),
        .sdram_dout ( sdram_dout ),
        .rst        ( rst        ),
        .game_rst   ( game_rst   ),
        .sdram_init ( sdram_init ),
        .sdram_dq   ( sdram_dq   ),
        .sdram_a    ( sdram_a    ),
        .sdram_ba   ( sdram_ba   ),
        .sdram_dqml ( sdram_dqml ),
        .sdram_dqmh ( sdram_dqmh ),
        .sdram_nwe  ( sdram_nwe  ),
        .sdram_ncas ( sdram_ncas ),
        .sdram_nras ( sdram_nras ),
        .sdram_ncs  ( sdram_ncs  ),
        .sdram_cke  ( sdram_cke  )
    );

    jtsd_sdram_model u_sdram(
        .clk        ( clk_rom    ),
        .sdram_dq   ( sdram_dq   ),
        .sdram_a    ( sdram_a    ),
        .sdram_ba   ( sdram_ba   ),
        .sdram_dqml ( sdram_dqml ),
        .sdram_dqmh ( sdram_dqmh ),
        .sdram_nwe  ( sdram_nwe  ),
        .sdram_ncas ( sdram_ncas ),
        .sdram_nras ( sdram_nras ),
        .sdram_ncs  ( sdram_ncs  ),
        .sdram_cke  ( sdram_cke  ),
        .rfsh_cnt   ( rfsh_cnt   )
    );

    initial begin
        clk_rom = 1'b0;
        forever #10 clk_rom = ~clk_rom;
    end

    always @(posedge clk_rom) begin
        cycle++;
        if (limit > 0 && cycle >= limit) begin
            $display("Error: run did not finish within %0d cycles", limit);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report(input string what);
        $display("Error at %0t ns: %s", $time, what);
        errors++;
    endtask

    // Preload rule, then writes applied with their byte masks
    function automatic logic [15:0] sb_read(input int port, input logic [21:0] a);
        int key;
        key = {port[1:0], a};
        if (sb.exists(key)) begin
            return sb[key];
        end
        return key[15:0] ^ 16'h5a5a;
    endfunction

    task automatic sb_write(input logic [21:0] a, input logic [15:0] d, input logic [1:0] m);
        logic [15:0] w;
        w = sb_read(0, a);
        if (!m[0]) w[7:0] = d[7:0];
        if (!m[1]) w[15:8] = d[15:8];
        sb[{2'd0, a}] = w;
    endtask

    // First pending port after the last winner
    function automatic int next_port(input logic [3:0] pend, input int last);
        int p;
        for (int k = 1; k <= 4; k++) begin
            p = (last + k) % 4;
            if (pend[p]) return p;
        end
        return -1;
    endfunction

    task automatic run_access(input byte opc, input int port, input logic [21:0] a,
                              input logic [15:0] d, input logic [1:0] m,
                              input logic [15:0] exp_d);
        logic [3:0]  ports;
        logic [3:0]  acked;
        logic [3:0]  done;
        logic        is_wr;
        logic [15:0] want;
        int          ack_cyc [4];
        is_wr = (opc == "W");
        ports = (opc == "C") ? 4'hf : 4'(1) << port;
        acked = '0;
        done  = '0;
        @(negedge clk_rom);
        ba0_addr  = a;
        ba1_addr  = a;
        ba2_addr  = a;
        ba3_addr  = a;
        ba0_din   = d;
        ba0_din_m = m;
        if (is_wr) wr0 = 1'b1;
        else rd = ports;
        while (done != ports) begin
            @(negedge clk_rom);
            for (int i = 0; i < 4; i++) begin
                if (ack[i]) begin
                    assert (ports[i] && !acked[i]) else begin
                        report($sformatf("port %0d got an ack it did not ask for", i));
                    end
                    if (ports[i] && !acked[i]) begin
                        check_val("acked port", next_port(ports & ~acked, last_winner), i);
                        acked[i]   = 1'b1;
                        ack_cyc[i] = cycle;
                        last_winner = i;
                        rd[i] = 1'b0;
                        if (i == 0) wr0 = 1'b0;
                    end
                end
                if (dok[i]) begin
                    assert (!is_wr && acked[i]) else begin
                        report($sformatf("port %0d got dok without a pending read", i));
                    end
                    if (!is_wr && acked[i]) begin
                        check_val($sformatf("dok[%0d] delay", i), CAS_LAT + 1,
                                  cycle - ack_cyc[i]);
                        want = (opc == "C") ? sb_read(i, a) : exp_d;
                        check_val($sformatf("sdram_dout port %0d", i), want, sdram_dout);
                    end
                end
                if (rdy[i]) begin
                    assert (acked[i] && !done[i]) else begin
                        report($sformatf("port %0d got rdy before ack or twice", i));
                    end
                    if (acked[i] && !done[i]) begin
                        check_val($sformatf("rdy[%0d] delay", i),
                                  is_wr ? T_RP + 1 : CAS_LAT + 2, cycle - ack_cyc[i]);
                    end
                    done[i] = 1'b1;
                end
            end
        end
        if (is_wr) sb_write(a, d, m);
    endtask

    // Line blanking, some pulses moved by a random offset
    initial begin
        int slot;
        int off;
        lhbl     = 1'b1;
        pulses   = 0;
        gen_done = 1'b0;
        slot     = 0;
        off      = 20;
        wait (arst_n && !sdram_init);
        while (!(gen_stop && lhbl)) begin
            if (slot == 0) begin
                if ($random(seed) & 1) off = 20 + ({$random(seed)} % 150);
                else off = 20;
            end
            if (slot == off) begin
                lhbl = 1'b0;
                pulses++;
            end
            if (slot == off + 8) lhbl = 1'b1;
            slot = (slot == 199) ? 0 : slot + 1;
            @(negedge clk_rom);
        end
        gen_done = 1'b1;
    end

    always @(negedge clk_rom) begin
        if (arst_n) begin
            assert (game_rst || !sdram_init) else begin
                report("game_rst low while sdram_init is high");
            end
            assert (sdram_cke) else begin
                report("sdram_cke dropped low");
            end
        end
    end

    initial begin
        int     fd;
        int     n;
        string  line;
        byte    opc;
        int     port;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] m;
        logic [31:0] e;
        errors      = 0;
        checks      = 0;
        cycle       = 0;
        limit       = 0;
        seed        = 32'h970caf91;
        gen_stop    = 1'b0;
        last_winner = 3;
        arst_n      = 1'b0;
        pll_locked  = 1'b1;
        rst_req     = 1'b0;
        ba0_addr    = '0;
        ba1_addr    = '0;
        ba2_addr    = '0;
        ba3_addr    = '0;
        rd          = '0;
        wr0         = 1'b0;
        ba0_din     = '0;
        ba0_din_m   = '0;
        fd = $fopen("verif/jtsd_patterns.txt", "r");
        if (fd == 0) begin
            report("cannot open verif/jtsd_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %d %h %h %h %h", opc, port, a, d, m, e);
                    if (n == 6) begin
                        op_q.push_back(opc);
                        port_q.push_back(port);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        mask_q.push_back(m);
                        exp_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
        limit = INIT_CYCLES + 60 * op_q.size() + 200;

        repeat (4) @(posedge clk_rom);
        @(negedge clk_rom);
        arst_n = 1'b1;
        @(negedge clk_rom);
        check_val("ack", 0, ack);
        check_val("dok", 0, dok);
        check_val("rdy", 0, rdy);
        check_val("rst", 1, rst);
        check_val("sdram_init", 1, sdram_init);
        check_val("game_rst", 1, game_rst);
        while (sdram_init) @(negedge clk_rom);
        // Game reset follows the end of init by one register stage
        @(negedge clk_rom);
        check_val("rst", 0, rst);
        check_val("game_rst", 0, game_rst);

        for (int k = 0; k < op_q.size(); k++) begin
            run_access(op_q[k], port_q[k], addr_q[k][21:0], data_q[k][15:0],
                       mask_q[k][1:0], exp_q[k][15:0]);
        end

        // Two refreshes belong to the init sequence
        gen_stop = 1'b1;
        wait (gen_done);
        repeat (30) @(negedge clk_rom);
        check_val("refresh count", pulses + 2, rfsh_cnt);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: jtsd_board.f
hdl/jtsd_sdram_pkg.sv
hdl/jtsd_board_pkg.sv
hdl/jtsd_reset.sv
hdl/jtsd_bank_port.sv
hdl/jtsd_arbiter.sv
hdl/jtsd_sdram_ctrl.sv
hdl/jtsd_board.sv
verif/jtsd_sdram_model.sv
verif/jtsd_board_tb.sv

// File: verif/jtsd_patterns.txt
# op port addr data mask expected (hex except port)
# W write port 0, R single read, C all four ports read addr
R 1 000010 0000 0 5a4a
R 2 000123 0000 0 5b79
R 3 3abcde 0000 0 e684
W 0 000040 1234 0 0000
R 0 000040 0000 0 1234
W 0 000041 abcd 1 0000
R 0 000041 0000 0 ab1b
W 0 000042 9876 2 0000
R 0 000042 0000 0 5a76
W 0 000043 ffff 3 0000
R 0 000043 0000 0 5a19
R 0 001200 0000 0 485a
C 0 000040 0000 0 0000
R 2 3fffff 0000 0 a5a5
R 1 155555 0000 0 0f0f
W 0 3fffff 00ff 0 0000
R 0 3fffff 0000 0 00ff
C 0 3fffff 0000 0 0000
C 0 000041 0000 0 0000
R 3 000010 0000 0 5a4a
C 0 155555 0000 0 0000
W 0 155555 c3c3 1 0000
C 0 155555 0000 0 0000
